//--- Bender.yml
package:
  name: soc_harness

sources:
  - source/soc_map_pkg.sv
  - source/irq_pkg.sv
  - source/rst_sync.sv
  - source/bus_xbar.sv
  - source/boot_rom.sv
  - source/sram.sv
  - source/debug_req_gate.sv
  - source/irq_router.sv
  - source/soc_harness.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_soc_harness.sv

//--- dv/harness_checks.svh
// ----------------------------------------------------------------------
// harness checks
// concurrent assertions that compare the harness outputs with the
// values expected by the testbench
// ----------------------------------------------------------------------

`ifndef HARNESS_CHECKS_SVH
`define HARNESS_CHECKS_SVH

  // ----------------------------------------------------------------------
  // reset
  // ----------------------------------------------------------------------
  assert property (@(posedge clk_i) !rst_ni |->
      (!soc_rst_no && !bus_rvalid_o && !debug_req_o && clic_irqs_o == '0))
    else report_mismatch("outputs not inactive while rst_ni is low");

  assert property (@(posedge clk_i) !causes_clear |-> !soc_rst_no)
    else report_mismatch("soc_rst_no high while a reset cause is active");

  // release on the second edge after both causes clear
  assert property (@(posedge clk_i) $rose(causes_clear) |->
      !soc_rst_no ##1 !soc_rst_no ##1 soc_rst_no)
    else report_mismatch("soc_rst_no not released on the second edge");

  // ----------------------------------------------------------------------
  // bus responses
  // ----------------------------------------------------------------------
  assert property (@(posedge clk_i) disable iff (!soc_rst_no)
      bus_req_i |=> bus_rvalid_o)
    else report_mismatch("missing bus_rvalid_o one cycle after a request");

  assert property (@(posedge clk_i) disable iff (!soc_rst_no)
      !bus_req_i |=> !bus_rvalid_o)
    else report_mismatch("bus_rvalid_o without a request");

  assert property (@(posedge clk_i) disable iff (!soc_rst_no)
      bus_req_i |=> bus_err_o == $past(exp_err))
    else report_mismatch("wrong bus_err_o");

  assert property (@(posedge clk_i) disable iff (!soc_rst_no)
      bus_req_i && exp_chk |=> bus_rdata_o == $past(exp_rdata))
    else report_mismatch("wrong bus_rdata_o");

  // ----------------------------------------------------------------------
  // debug gate and interrupts
  // ----------------------------------------------------------------------
  assert property (@(posedge clk_i)
      debug_req_o == ((rel_edges >= HoldoffCycles) && debug_req_i && debug_enable_i))
    else report_mismatch("debug_req_o breaks the hold-off rule");

  assert property (@(posedge clk_i) soc_rst_no && $past(soc_rst_no) |->
      clic_irqs_o == expected_irqs($past(ipi_i), $past(timer_irq_i),
                                   $past(seip_i), $past(meip_i)))
    else report_mismatch("wrong clic_irqs_o");

`endif

//--- dv/tb_soc_harness.sv
// ----------------------------------------------------------------------
// soc harness testbench
// drives reset, bus traffic, debug requests and interrupts into the
// harness, with a memory model and a cycle limit
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_soc_harness;

  import soc_map_pkg::*;

  localparam int unsigned NumWords      = 64;
  localparam int unsigned HoldoffCycles = 20;
  localparam int unsigned MaxCycles     = 2000;
  localparam time         DriveDelay    = 2;

  logic               clk_i;
  logic               rst_ni;
  logic               ndmreset_i;
  logic               bus_req_i;
  logic               bus_we_i;
  addr_t              bus_addr_i;
  strb_t              bus_be_i;
  data_t              bus_wdata_i;
  logic               debug_req_i;
  logic               debug_enable_i;
  logic               meip_i;
  logic               seip_i;
  logic               timer_irq_i;
  logic               ipi_i;
  logic               soc_rst_no;
  logic               bus_rvalid_o;
  data_t              bus_rdata_o;
  logic               bus_err_o;
  logic               debug_req_o;
  irq_pkg::clic_src_t clic_irqs_o;

  // expected response of the request now on the bus
  logic        exp_err;
  logic        exp_chk;
  data_t       exp_rdata;
  data_t       mem_model [NumWords];
  logic [63:0] rng_state;
  int unsigned cycle_cnt  = 0;
  int unsigned rel_edges  = 0;
  logic        causes_clear;

  assign causes_clear = rst_ni & ~ndmreset_i;

  soc_harness #(
    .NumWords      ( NumWords      ),
    .HoldoffCycles ( HoldoffCycles )
  ) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // edges since power-on reset release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rel_edges <= 0;
    end else if (rel_edges < MaxCycles) begin
      rel_edges <= rel_edges + 1;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("timeout: the run did not finish within %0d cycles", MaxCycles);
      stop_run();
    end
  end

  task automatic stop_run();
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string what);
    $display("ERR @ %0t: %s", $time, what);
    stop_run();
  endtask

  function automatic logic [63:0] next_rand();
    logic [63:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    rng_state = x;
    return x;
  endfunction

  // software, timer, supervisor and machine external at 3, 7, 9, 11
  function automatic irq_pkg::clic_src_t expected_irqs(input logic msip, input logic mtip,
                                                       input logic seip, input logic meip);
    irq_pkg::clic_src_t v;
    v     = '0;
    v[3]  = msip;
    v[7]  = mtip;
    v[9]  = seip;
    v[11] = meip;
    return v;
  endfunction

  task automatic issue(input logic we, input addr_t addr, input strb_t be, input data_t wdata,
                       input logic err, input logic chk, input data_t rdata);
    @(posedge clk_i);
    #DriveDelay;
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_addr_i  = addr;
    bus_be_i    = be;
    bus_wdata_i = wdata;
    exp_err     = err;
    exp_chk     = chk;
    exp_rdata   = rdata;
  endtask

  task automatic idle();
    @(posedge clk_i);
    #DriveDelay;
    bus_req_i = 1'b0;
    bus_we_i  = 1'b0;
    exp_err   = 1'b0;
    exp_chk   = 1'b0;
  endtask

  // reads return the word before the write of the same cycle
  task automatic sram_access(input int unsigned idx, input logic we, input strb_t be,
                             input data_t wdata);
    issue(we, DramBase + (addr_t'(idx) << 3), be, wdata, 1'b0, !we, mem_model[idx]);
    if (we) begin
      for (int b = 0; b < 8; b++) begin
        if (be[b]) begin
          mem_model[idx][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end
  endtask

  task automatic rom_access(input addr_t off, input logic we);
    data_t expected;
    expected = {RomTag, 32'((off / 8) % RomWords)};
    issue(we, RomBase + off, '1, next_rand(), 1'b0, !we, expected);
  endtask

  task automatic err_access(input addr_t addr, input logic we);
    issue(we, addr, '1, next_rand(), 1'b1, 1'b1, '0);
  endtask

  initial begin
    logic [63:0] r;
    logic [3:0]  irq_set [9];
    irq_set = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011,
                4'b1100, 4'b1010, 4'b1111, 4'b0000};
    rng_state      = 64'd81106;
    // clean falling edge for the asynchronous resets
    rst_ni         = 1'b1;
    ndmreset_i     = 1'b0;
    bus_req_i      = 1'b0;
    bus_we_i       = 1'b0;
    bus_addr_i     = '0;
    bus_be_i       = '0;
    bus_wdata_i    = '0;
    debug_req_i    = 1'b1;
    debug_enable_i = 1'b1;
    meip_i         = 1'b0;
    seip_i         = 1'b0;
    timer_irq_i    = 1'b0;
    ipi_i          = 1'b0;
    exp_err        = 1'b0;
    exp_chk        = 1'b0;
    exp_rdata      = '0;
    #DriveDelay;
    rst_ni = 1'b0;
    repeat (5) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;
    wait (soc_rst_no === 1'b1);

    // ------------------------------------------------------------------
    // sram fill, random writes, random reads
    // ------------------------------------------------------------------
    for (int unsigned i = 0; i < NumWords; i++) begin
      sram_access(i, 1'b1, '1, 64'h9E37_79B9_7F4A_7C15 * (i + 1));
    end
    for (int n = 0; n < 40; n++) begin
      r = next_rand();
      sram_access(int'(r % NumWords), 1'b1, r[15:8], next_rand());
    end
    for (int n = 0; n < 40; n++) begin
      sram_access(int'(next_rand() % NumWords), 1'b0, '0, '0);
    end
    idle();

    // debug disabled, then request dropped and raised again
    debug_enable_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #DriveDelay;
    debug_enable_i = 1'b1;
    debug_req_i    = 1'b0;
    repeat (3) @(posedge clk_i);
    #DriveDelay;
    debug_req_i = 1'b1;

    // ------------------------------------------------------------------
    // boot rom and error region
    // ------------------------------------------------------------------
    for (int n = 0; n < 12; n++) begin
      rom_access(addr_t'(next_rand() & 64'hFFFF), 1'b0);
    end
    rom_access(64'h18, 1'b1);
    rom_access(64'h18, 1'b0);
    rom_access(64'hFFFF, 1'b0);
    err_access(GpioBase, 1'b0);
    sram_access(3, 1'b0, '0, '0);
    err_access(GpioBase + 64'h800, 1'b1);
    sram_access(5, 1'b1, 8'h3C, next_rand());
    err_access(64'h2000_0000, 1'b0);
    sram_access(5, 1'b0, '0, '0);
    err_access(DramBase + NumWords * 8, 1'b0);
    rom_access(64'h40, 1'b0);
    idle();

    // interrupts alone and combined, two cycles each
    for (int k = 0; k < 9; k++) begin
      @(posedge clk_i);
      #DriveDelay;
      {meip_i, seip_i, timer_irq_i, ipi_i} = irq_set[k];
      @(posedge clk_i);
    end

    // debug system reset keeps the sram contents
    @(posedge clk_i);
    #DriveDelay;
    ndmreset_i = 1'b1;
    repeat (3) @(posedge clk_i);
    #DriveDelay;
    ndmreset_i = 1'b0;
    wait (soc_rst_no === 1'b1);
    sram_access(5, 1'b0, '0, '0);
    idle();
    repeat (2) @(posedge clk_i);

    $display("Everything OK");
    $finish;
  end

  `include "harness_checks.svh"

endmodule

//--- sim.f
+incdir+dv
source/soc_map_pkg.sv
source/irq_pkg.sv
source/rst_sync.sv
source/bus_xbar.sv
source/boot_rom.sv
source/sram.sv
source/debug_req_gate.sv
source/irq_router.sv
source/soc_harness.sv
dv/tb_soc_harness.sv

//--- source/boot_rom.sv
// ----------------------------------------------------------------------
// boot rom
// fixed boot words tagged with their index, registered read
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module boot_rom (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      req_i,
  input  logic [$clog2(soc_map_pkg::RomWords)-1:0] idx_i,
  output soc_map_pkg::data_t                        rdata_o
);

  import soc_map_pkg::*;

  data_t rom_table [RomWords];

  // tag in the upper half, word index in the lower half
  always_comb begin
    for (int unsigned i = 0; i < RomWords; i++) begin
      rom_table[i] = {RomTag, (DataWidth/2)'(i)};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= rom_table[idx_i];
    end
  end

endmodule

//--- source/bus_xbar.sv
// ----------------------------------------------------------------------
// bus crossbar
// decodes requests against the address map and returns the response
// of the selected target one cycle later
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module bus_xbar #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      req_i,
  input  logic                                      we_i,
  input  soc_map_pkg::addr_t                        addr_i,
  input  soc_map_pkg::strb_t                        be_i,
  input  soc_map_pkg::data_t                        wdata_i,
  input  soc_map_pkg::data_t                        rom_rdata_i,
  input  soc_map_pkg::data_t                        mem_rdata_i,
  output logic                                      rvalid_o,
  output soc_map_pkg::data_t                        rdata_o,
  output logic                                      err_o,
  output logic                                      rom_req_o,
  output logic [$clog2(soc_map_pkg::RomWords)-1:0] rom_idx_o,
  output logic                                      mem_req_o,
  output logic                                      mem_we_o,
  output logic [$clog2(NumWords)-1:0]               mem_idx_o,
  output soc_map_pkg::strb_t                        mem_be_o,
  output soc_map_pkg::data_t                        mem_wdata_o
);

  import soc_map_pkg::*;

  localparam int unsigned ByteOffset  = $clog2(DataWidth/8);
  localparam int unsigned RomIdxWidth = $clog2(RomWords);
  localparam int unsigned MemIdxWidth = $clog2(NumWords);
  localparam addr_t       DramLength  = addr_t'(NumWords) << ByteOffset;

  logic    in_rom;
  logic    in_dram;
  addr_t   rom_off;
  addr_t   mem_off;
  region_e region_d;
  region_e region_q;
  logic    rvalid_q;

  // ----------------------------------------------------------------------
  // address decode
  // ----------------------------------------------------------------------
  assign in_rom  = (addr_i >= RomBase) && (addr_i < RomBase + RomLength);
  assign in_dram = (addr_i >= DramBase) && (addr_i < DramBase + DramLength);

  // gpio has no device, so it answers like any unmapped address
  always_comb begin
    region_d = RegionErr;
    if (in_rom) begin
      region_d = RegionRom;
    end else if (in_dram) begin
      region_d = RegionDram;
    end
  end

  // word offsets inside each region
  assign rom_off = addr_i - RomBase;
  assign mem_off = addr_i - DramBase;

  // rom ignores writes
  assign rom_req_o = req_i & in_rom & ~we_i;
  assign rom_idx_o = rom_off[ByteOffset +: RomIdxWidth];

  assign mem_req_o   = req_i & in_dram;
  assign mem_we_o    = req_i & in_dram & we_i;
  assign mem_idx_o   = mem_off[ByteOffset +: MemIdxWidth];
  assign mem_be_o    = be_i;
  assign mem_wdata_o = wdata_i;

  // ----------------------------------------------------------------------
  // response path
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      region_q <= RegionErr;
    end else begin
      rvalid_q <= req_i;
      region_q <= region_d;
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q && (region_q == RegionErr);

  always_comb begin
    case (region_q)
      RegionRom:  rdata_o = rom_rdata_i;
      RegionDram: rdata_o = mem_rdata_i;
      default:    rdata_o = '0;
    endcase
  end

endmodule

//--- source/debug_req_gate.sv
// ----------------------------------------------------------------------
// debug request gate
// blocks debug requests for a window after power-on reset, then
// passes them while debugging is enabled
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module debug_req_gate #(
  parameter int unsigned HoldoffCycles = 20
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = $clog2(HoldoffCycles + 1);

  logic [CntWidth-1:0] cnt_q;
  logic                holdoff;

  assign holdoff = (cnt_q != '0);

  // gives the hart time to run boot code before the first halt
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(HoldoffCycles);
    end else if (holdoff) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = ~holdoff & debug_req_i & debug_enable_i;

endmodule

//--- source/irq_pkg.sv
// ----------------------------------------------------------------------
// interrupt vectors
// widths of the local and controller vectors and the bit positions
// of the architectural interrupts
// ----------------------------------------------------------------------

package irq_pkg;

  // local vector, one bit per mip position
  localparam int unsigned Xlen       = 64;
  // controller source vector, upper bits are platform defined
  localparam int unsigned ClicNumSrc = 256;

  // mip bit positions
  localparam int unsigned MsipBit = 3;
  localparam int unsigned MtipBit = 7;
  localparam int unsigned SeipBit = 9;
  localparam int unsigned MeipBit = 11;

  typedef logic [ClicNumSrc-1:0] clic_src_t;

endpackage

//--- source/irq_router.sv
// ----------------------------------------------------------------------
// interrupt router
// packs the hart interrupts into the local vector and registers it
// into the interrupt controller source vector
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module irq_router (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               meip_i,
  input  logic               seip_i,
  input  logic               timer_irq_i,
  input  logic               ipi_i,
  output irq_pkg::clic_src_t irqs_o
);

  import irq_pkg::*;

  logic [Xlen-1:0] local_irqs;

  // mip layout, reserved and platform bits stay low
  always_comb begin
    local_irqs          = '0;
    local_irqs[MsipBit] = ipi_i;
    local_irqs[MtipBit] = timer_irq_i;
    local_irqs[SeipBit] = seip_i;
    local_irqs[MeipBit] = meip_i;
  end

  // upper sources are zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irqs_o <= '0;
    end else begin
      irqs_o <= {{(ClicNumSrc - Xlen){1'b0}}, local_irqs};
    end
  end

endmodule

//--- source/rst_sync.sv
// ----------------------------------------------------------------------
// system reset generator
// merges power-on and debug reset, releases through two flops
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module rst_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic rst_no
);

  logic       rst_comb_n;
  logic [1:0] sync_q;

  // either cause asserts the reset at once
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // release on the second edge after both causes clear
  assign rst_no = sync_q[1];

endmodule

//--- source/soc_harness.sv
// ----------------------------------------------------------------------
// soc harness
// reset, bus decode, memories, debug gating and interrupt routing
// around a single hart
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module soc_harness #(
  parameter int unsigned NumWords      = 1024,
  parameter int unsigned HoldoffCycles = 20
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ndmreset_i,
  input  logic               bus_req_i,
  input  logic               bus_we_i,
  input  soc_map_pkg::addr_t bus_addr_i,
  input  soc_map_pkg::strb_t bus_be_i,
  input  soc_map_pkg::data_t bus_wdata_i,
  input  logic               debug_req_i,
  input  logic               debug_enable_i,
  input  logic               meip_i,
  input  logic               seip_i,
  input  logic               timer_irq_i,
  input  logic               ipi_i,
  output logic               soc_rst_no,
  output logic               bus_rvalid_o,
  output soc_map_pkg::data_t bus_rdata_o,
  output logic               bus_err_o,
  output logic               debug_req_o,
  output irq_pkg::clic_src_t clic_irqs_o
);

  import soc_map_pkg::*;

  logic                        rom_req;
  logic [$clog2(RomWords)-1:0] rom_idx;
  data_t                       rom_rdata;
  logic                        mem_req;
  logic                        mem_we;
  logic [$clog2(NumWords)-1:0] mem_idx;
  strb_t                       mem_be;
  data_t                       mem_wdata;
  data_t                       mem_rdata;

  // ----------------------------------------------------------------------
  // reset
  // ----------------------------------------------------------------------
  rst_sync i_rst_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .rst_no     ( soc_rst_no )
  );

  // ----------------------------------------------------------------------
  // bus and memories
  // ----------------------------------------------------------------------
  bus_xbar #(
    .NumWords ( NumWords )
  ) i_bus_xbar (
    .clk_i       ( clk_i        ),
    .rst_ni      ( soc_rst_no   ),
    .req_i       ( bus_req_i    ),
    .we_i        ( bus_we_i     ),
    .addr_i      ( bus_addr_i   ),
    .be_i        ( bus_be_i     ),
    .wdata_i     ( bus_wdata_i  ),
    .rom_rdata_i ( rom_rdata    ),
    .mem_rdata_i ( mem_rdata    ),
    .rvalid_o    ( bus_rvalid_o ),
    .rdata_o     ( bus_rdata_o  ),
    .err_o       ( bus_err_o    ),
    .rom_req_o   ( rom_req      ),
    .rom_idx_o   ( rom_idx      ),
    .mem_req_o   ( mem_req      ),
    .mem_we_o    ( mem_we       ),
    .mem_idx_o   ( mem_idx      ),
    .mem_be_o    ( mem_be       ),
    .mem_wdata_o ( mem_wdata    )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i      ),
    .rst_ni  ( soc_rst_no ),
    .req_i   ( rom_req    ),
    .idx_i   ( rom_idx    ),
    .rdata_o ( rom_rdata  )
  );

  sram #(
    .NumWords ( NumWords )
  ) i_sram (
    .clk_i   ( clk_i     ),
    .req_i   ( mem_req   ),
    .we_i    ( mem_we    ),
    .idx_i   ( mem_idx   ),
    .be_i    ( mem_be    ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

  // ----------------------------------------------------------------------
  // debug and interrupts
  // ----------------------------------------------------------------------
  // hold-off runs from power-on reset only
  debug_req_gate #(
    .HoldoffCycles ( HoldoffCycles )
  ) i_debug_req_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

  irq_router i_irq_router (
    .clk_i       ( clk_i       ),
    .rst_ni      ( soc_rst_no  ),
    .meip_i      ( meip_i      ),
    .seip_i      ( seip_i      ),
    .timer_irq_i ( timer_irq_i ),
    .ipi_i       ( ipi_i       ),
    .irqs_o      ( clic_irqs_o )
  );

endmodule

//--- source/soc_map_pkg.sv
// ----------------------------------------------------------------------
// soc memory map
// bus widths, bus payload types and the address map of the harness
// ----------------------------------------------------------------------

package soc_map_pkg;

  // bus widths
  localparam int unsigned AddrWidth = 64;
  localparam int unsigned DataWidth = 64;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [DataWidth/8-1:0] strb_t;

  // ----------------------------------------------------------------------
  // address map
  // ----------------------------------------------------------------------
  localparam addr_t RomBase    = 64'h0000_0000_0001_0000;
  localparam addr_t RomLength  = 64'h0000_0000_0001_0000;
  // gpio is mapped but has no device behind it
  localparam addr_t GpioBase   = 64'h0000_0000_4000_0000;
  localparam addr_t GpioLength = 64'h0000_0000_0000_1000;
  // dram length follows the sram depth of the top level
  localparam addr_t DramBase   = 64'h0000_0000_8000_0000;

  // boot rom contents
  localparam int unsigned           RomWords = 8;
  localparam logic [DataWidth/2-1:0] RomTag  = 32'hB007_B007;

  // target of a bus request
  typedef enum logic [1:0] {
    RegionRom,
    RegionDram,
    RegionErr
  } region_e;

endpackage

//--- source/sram.sv
// ----------------------------------------------------------------------
// main memory
// single-port sram with byte enables and a registered read that
// returns the word as it was before a same-cycle write
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module sram #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                        clk_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] idx_i,
  input  soc_map_pkg::strb_t          be_i,
  input  soc_map_pkg::data_t          wdata_i,
  output soc_map_pkg::data_t          rdata_o
);

  import soc_map_pkg::*;

  localparam int unsigned NumBytes = DataWidth / 8;

  data_t mem_q [NumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      // old word goes out, the write lands on the same edge
      rdata_o <= mem_q[idx_i];
      if (we_i) begin
        for (int unsigned b = 0; b < NumBytes; b++) begin
          if (be_i[b]) begin
            mem_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end
    end
  end

endmodule
